/* Bender.yml */
package:
  name: cpu_core

sources:
  - rtl/isaPkg.sv
  - rtl/cpuPkg.sv
  - rtl/execBus.sv
  - rtl/instrMem.sv
  - rtl/regFile.sv
  - rtl/decodeUnit.sv
  - rtl/execUnit.sv
  - rtl/dataMem.sv
  - rtl/cpuCore.sv
  - target: test
    files:
      - tests/cpuChecker.sv
      - tests/cpuTb.sv

/* list.f */
rtl/isaPkg.sv
rtl/cpuPkg.sv
rtl/execBus.sv
rtl/instrMem.sv
rtl/regFile.sv
rtl/decodeUnit.sv
rtl/execUnit.sv
rtl/dataMem.sv
rtl/cpuCore.sv
tests/cpuChecker.sv
tests/cpuTb.sv

/* rtl/cpuCore.sv */
`timescale 1ns/100ps
`default_nettype none

// Two-stage core top: fetch/decode then execute
module cpuCore import cpuPkg::*; #(
	parameter int imemDepth = 256,
	parameter int dmemDepth = 256
) (
	input  logic   clk,
	input  logic   rst,
	// Program load, used while rst is high
	input  logic   imemWrEn,
	input  wordT   imemWrAddr,
	input  wordT   imemWrData,
	output wordT   pc,
	// Register write of the execute stage
	output logic   regWrEn,
	output regIdxT regWrAddr,
	output wordT   regWrData,
	// Data memory write of the execute stage
	output logic   memWrEn,
	output wordT   memAddr,
	output wordT   memWrData,
	output logic   halted
);
	wordT   instr;
	regIdxT rdAddrA;
	regIdxT rdAddrB;
	wordT   rdDataA;
	wordT   rdDataB;
	flagsT  flagsNext;
	wordT   memRdData;

	execBus stageBus ();

	instrMem #(.imemDepth(imemDepth)) instrMem_i (
		.clk, .wrEn(imemWrEn), .wrAddr(imemWrAddr), .wrData(imemWrData),
		.addr(pc), .instr
	);

	regFile regFile_i (
		.clk, .rst, .rdAddrA, .rdAddrB,
		.wrEn(regWrEn), .wrAddr(regWrAddr), .wrData(regWrData),
		.rdDataA, .rdDataB
	);

	decodeUnit #(.imemDepth(imemDepth)) decodeUnit_i (
		.clk, .rst, .instr, .rdDataA, .rdDataB, .flagsNext,
		.pc, .rdAddrA, .rdAddrB, .halted, .bus(stageBus.dec)
	);

	// Write-back outputs double as the top-level write ports
	execUnit execUnit_i (
		.clk, .rst, .memRdData,
		.wbEn(regWrEn), .wbAddr(regWrAddr), .wbData(regWrData),
		.memAddr, .memWrEn, .memWrData, .flagsNext, .bus(stageBus.exe)
	);

	dataMem #(.dmemDepth(dmemDepth)) dataMem_i (
		.clk, .wrEn(memWrEn), .addr(memAddr), .wrData(memWrData), .rdData(memRdData)
	);

endmodule

`default_nettype wire

/* rtl/cpuPkg.sv */
`default_nettype none

// Datapath types shared by the pipeline stages
package cpuPkg;

	typedef logic [15:0] wordT;

	typedef logic [2:0] regIdxT;

	// Operations of the execute stage ALU and shifter
	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluXor = 3'd4,
		aluShl = 3'd5,
		aluShr = 3'd6
	} aluOpT;

	// Source of the register write-back value
	typedef enum logic [1:0] {
		wbAlu  = 2'd0,
		wbMem  = 2'd1,
		wbImm  = 2'd2,
		wbLink = 2'd3
	} wbSelT;

	// Condition flags, no carry or overflow
	typedef struct packed {
		logic n;
		logic z;
	} flagsT;

endpackage

`default_nettype wire

/* rtl/dataMem.sv */
`timescale 1ns/100ps
`default_nettype none

// Word-addressed data store
module dataMem import cpuPkg::*; #(
	parameter int dmemDepth = 256
) (
	input  logic clk,
	input  logic wrEn,
	input  wordT addr,
	input  wordT wrData,
	output wordT rdData
);
	// Address wraps at the power-of-two depth
	localparam int addrBits = $clog2(dmemDepth);

	wordT mem [dmemDepth];
	logic [addrBits-1:0] idx;

	assign idx = addr[addrBits-1:0];

	// STR commits at the end of its execute cycle
	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[idx] <= wrData;
		end
	end

	// LDR data is back within the same cycle
	assign rdData = mem[idx];

endmodule

`default_nettype wire

/* rtl/decodeUnit.sv */
`timescale 1ns/100ps
`default_nettype none

// Fetch and decode stage with PC, branch resolution and halt
module decodeUnit import cpuPkg::*, isaPkg::*; #(
	parameter int imemDepth = 256
) (
	input  logic   clk,
	input  logic   rst,
	input  wordT   instr,
	input  wordT   rdDataA,
	input  wordT   rdDataB,
	input  flagsT  flagsNext,
	output wordT   pc,
	output regIdxT rdAddrA,
	output regIdxT rdAddrB,
	output logic   halted,
	execBus.dec    bus
);
	localparam int pcBits = $clog2(imemDepth);

	instrWordT  iw;
	opcodeT     op;
	logic [11:0] brFar;
	wordT       brOffset;
	wordT       pcPlusOne;
	wordT       pcNext;
	logic       condMet;
	logic       branchTaken;
	logic       jumpReg;
	logic       isHlt;
	// Decoded control, registered onto the bus
	logic       dRegWrite;
	logic       dMemWrite;
	logic       dMemRead;
	logic       dSetFlags;
	aluOpT      dAluOp;
	wbSelT      dWbSel;
	wordT       dOpB;
	wordT       dImm;
	regIdxT     dRd;

	assign iw = instr;
	assign op = iw.r.op;

	// Ports read ra and rb, STR reads its data register instead of rb
	assign rdAddrA = iw.r.ra;
	assign rdAddrB = (op == opStr) ? iw.i.rd : iw.r.rb;

	// Flags come from the bypass, so the instruction just ahead counts
	always_comb begin
		case (iw.b.cond)
			condEq:  condMet = flagsNext.z;
			condNe:  condMet = !flagsNext.z;
			condMi:  condMet = flagsNext.n;
			default: condMet = !flagsNext.n;
		endcase
	end

	// Long offset of B and BL
	assign brFar = {iw.b.cond, iw.b.off};

	always_comb begin
		dRegWrite   = 1'b0;
		dMemWrite   = 1'b0;
		dMemRead    = 1'b0;
		dSetFlags   = 1'b0;
		dAluOp      = aluAdd;
		dWbSel      = wbAlu;
		dOpB        = rdDataB;
		dImm        = wordT'(iw.i.imm);
		dRd         = iw.r.rd;
		brOffset    = '0;
		branchTaken = 1'b0;
		jumpReg     = 1'b0;
		isHlt       = 1'b0;
		case (op)
			opAdd, opSub, opAnd, opOrr, opXor, opLsl, opLsr: begin
				dRegWrite = 1'b1;
				dSetFlags = 1'b1;
				case (op)
					opSub:   dAluOp = aluSub;
					opAnd:   dAluOp = aluAnd;
					opOrr:   dAluOp = aluOr;
					opXor:   dAluOp = aluXor;
					opLsl:   dAluOp = aluShl;
					opLsr:   dAluOp = aluShr;
					default: dAluOp = aluAdd;
				endcase
			end
			opAddi: begin
				dRegWrite = 1'b1;
				dSetFlags = 1'b1;
				dOpB      = dImm;
			end
			opMovi: begin
				dRegWrite = 1'b1;
				dWbSel    = wbImm;
				dImm      = wordT'(iw.m.imm);
			end
			opLdr: begin
				dRegWrite = 1'b1;
				dMemRead  = 1'b1;
				dWbSel    = wbMem;
			end
			opStr: begin
				dMemWrite = 1'b1;
			end
			opB: begin
				branchTaken = 1'b1;
				brOffset    = {{4{brFar[11]}}, brFar};
			end
			opBcc: begin
				branchTaken = condMet;
				brOffset    = {{6{iw.b.off[9]}}, iw.b.off};
			end
			opBl: begin
				branchTaken = 1'b1;
				brOffset    = {{4{brFar[11]}}, brFar};
				dRegWrite   = 1'b1;
				dWbSel      = wbLink;
				dRd         = lrIdx;
			end
			opBx: begin
				jumpReg = 1'b1;
			end
			default: begin
				isHlt = 1'b1;
			end
		endcase
	end

	assign pcPlusOne = pc + wordT'(1);

	// Next PC, resolved here so there is no delay slot
	always_comb begin
		if (halted || isHlt) begin
			// PC parks on the HLT word
			pcNext = pc;
		end else if (jumpReg) begin
			pcNext = rdDataA;
		end else if (branchTaken) begin
			pcNext = pc + brOffset;
		end else begin
			pcNext = pcPlusOne;
		end
	end

	// PC, halt and stage control
	always_ff @(posedge clk) begin
		if (rst) begin
			pc           <= '0;
			halted       <= 1'b0;
			bus.valid    <= 1'b0;
			bus.regWrite <= 1'b0;
			bus.memWrite <= 1'b0;
			bus.memRead  <= 1'b0;
			bus.setFlags <= 1'b0;
		end else begin
			pc           <= wordT'(pcNext[pcBits-1:0]);
			halted       <= halted | isHlt;
			// Nothing after HLT reaches execute
			bus.valid    <= !halted && !isHlt;
			bus.regWrite <= dRegWrite;
			bus.memWrite <= dMemWrite;
			bus.memRead  <= dMemRead;
			bus.setFlags <= dSetFlags;
		end
	end

	// Stage payload
	always_ff @(posedge clk) begin
		bus.aluOp     <= dAluOp;
		bus.wbSel     <= dWbSel;
		bus.opA       <= rdDataA;
		bus.opB       <= dOpB;
		bus.storeData <= rdDataB;
		bus.rd        <= dRd;
		bus.linkPc    <= pcPlusOne;
		bus.imm       <= dImm;
	end

endmodule

`default_nettype wire

/* rtl/execBus.sv */
`timescale 1ns/100ps
`default_nettype none

// Decode to execute stage register, no handshake
interface execBus import cpuPkg::*; ();
	// Slot holds a live instruction for exactly one cycle
	logic   valid;
	// Control word
	aluOpT  aluOp;
	wbSelT  wbSel;
	logic   regWrite;
	logic   memWrite;
	logic   memRead;
	logic   setFlags;
	// Operands and destination
	wordT   opA;
	wordT   opB;
	wordT   storeData;
	regIdxT rd;
	// Return address for BL
	wordT   linkPc;
	// Zero-extended immediate, also the memory offset
	wordT   imm;

	modport dec (output valid, aluOp, wbSel, regWrite, memWrite, memRead, setFlags,
		opA, opB, storeData, rd, linkPc, imm);

	modport exe (input valid, aluOp, wbSel, regWrite, memWrite, memRead, setFlags,
		opA, opB, storeData, rd, linkPc, imm);
endinterface

`default_nettype wire

/* rtl/execUnit.sv */
`timescale 1ns/100ps
`default_nettype none

// Execute stage: ALU, shifter, flags, memory request, write-back
module execUnit import cpuPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  wordT   memRdData,
	output logic   wbEn,
	output regIdxT wbAddr,
	output wordT   wbData,
	output wordT   memAddr,
	output logic   memWrEn,
	output wordT   memWrData,
	output flagsT  flagsNext,
	execBus.exe    bus
);
	wordT  aluRes;
	flagsT flagsQ;
	flagsT aluFlags;
	logic  memAccess;

	// Shift amount is the low nibble of opB
	always_comb begin
		case (bus.aluOp)
			aluSub:  aluRes = bus.opA - bus.opB;
			aluAnd:  aluRes = bus.opA & bus.opB;
			aluOr:   aluRes = bus.opA | bus.opB;
			aluXor:  aluRes = bus.opA ^ bus.opB;
			aluShl:  aluRes = bus.opA << bus.opB[3:0];
			aluShr:  aluRes = bus.opA >> bus.opB[3:0];
			default: aluRes = bus.opA + bus.opB;
		endcase
	end

	// Base plus offset, idle at zero
	assign memAccess = bus.memRead | bus.memWrite;
	assign memAddr   = memAccess ? bus.opA + bus.imm : '0;
	assign memWrData = bus.storeData;
	assign memWrEn   = bus.valid & bus.memWrite;

	// Write-back source
	always_comb begin
		case (bus.wbSel)
			wbMem:   wbData = memRdData;
			wbImm:   wbData = bus.imm;
			wbLink:  wbData = bus.linkPc;
			default: wbData = aluRes;
		endcase
	end

	assign wbEn   = bus.valid & bus.regWrite;
	assign wbAddr = bus.rd;

	assign aluFlags.n = aluRes[15];
	assign aluFlags.z = (aluRes == '0);

	// Flags after this instruction, seen by a BCC in decode now
	assign flagsNext = (bus.valid && bus.setFlags) ? aluFlags : flagsQ;

	always_ff @(posedge clk) begin
		if (rst) begin
			flagsQ <= '0;
		end else begin
			flagsQ <= flagsNext;
		end
	end

endmodule

`default_nettype wire

/* rtl/instrMem.sv */
`timescale 1ns/100ps
`default_nettype none

// Program store, loaded while the core is in reset
module instrMem import cpuPkg::*; #(
	parameter int imemDepth = 256
) (
	input  logic clk,
	input  logic wrEn,
	input  wordT wrAddr,
	input  wordT wrData,
	input  wordT addr,
	output wordT instr
);
	// Depth is a power of two, so dropping high bits wraps
	localparam int addrBits = $clog2(imemDepth);

	wordT mem [imemDepth];

	// Load port
	always_ff @(posedge clk) begin
		if (wrEn) begin
			mem[wrAddr[addrBits-1:0]] <= wrData;
		end
	end

	// Fetch is combinational at the PC
	assign instr = mem[addr[addrBits-1:0]];

endmodule

`default_nettype wire

/* rtl/isaPkg.sv */
`default_nettype none

// Instruction set of the 16-bit load/store core
package isaPkg;

	// Major opcode in bits 15 to 12
	typedef enum logic [3:0] {
		opAdd  = 4'h0,
		opSub  = 4'h1,
		opAnd  = 4'h2,
		opOrr  = 4'h3,
		opXor  = 4'h4,
		opLsl  = 4'h5,
		opLsr  = 4'h6,
		opAddi = 4'h7,
		opMovi = 4'h8,
		opLdr  = 4'h9,
		opStr  = 4'hA,
		opB    = 4'hB,
		opBcc  = 4'hC,
		opBl   = 4'hD,
		opBx   = 4'hE,
		opHlt  = 4'hF
	} opcodeT;

	// BCC condition in bits 11 to 10
	typedef enum logic [1:0] {
		condEq = 2'd0,
		condNe = 2'd1,
		condMi = 2'd2,
		condPl = 2'd3
	} condT;

	// ALU, shift and BX; BX jumps to ra
	typedef struct packed {
		opcodeT     op;
		logic [2:0] rd;
		logic [2:0] ra;
		logic [2:0] rb;
		logic [2:0] spare;
	} rFmtT;

	// ADDI, LDR, STR with zero-extended offset
	// STR takes its data from rd
	typedef struct packed {
		opcodeT     op;
		logic [2:0] rd;
		logic [2:0] ra;
		logic [5:0] imm;
	} iFmtT;

	// MOVI
	typedef struct packed {
		opcodeT     op;
		logic [2:0] rd;
		logic [8:0] imm;
	} mFmtT;

	// BCC offset is off alone, B and BL use {cond, off} as twelve bits
	typedef struct packed {
		opcodeT     op;
		condT       cond;
		logic [9:0] off;
	} bFmtT;

	// One fetched word, viewed by format
	typedef union packed {
		rFmtT r;
		iFmtT i;
		mFmtT m;
		bFmtT b;
	} instrWordT;

	// BL writes the return address here
	localparam logic [2:0] lrIdx = 3'd7;

endpackage

`default_nettype wire

/* rtl/regFile.sv */
`timescale 1ns/100ps
`default_nettype none

// Eight general registers, r7 doubles as link register
module regFile import cpuPkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  regIdxT rdAddrA,
	input  regIdxT rdAddrB,
	input  logic   wrEn,
	input  regIdxT wrAddr,
	input  wordT   wrData,
	output wordT   rdDataA,
	output wordT   rdDataB
);
	wordT regs [8];
	logic hitA;
	logic hitB;

	// Write lands at the edge that ends the execute cycle
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int idx = 0; idx < 8; idx++) begin
				regs[idx] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Decode reads the same register execute is writing
	assign hitA = wrEn && (wrAddr == rdAddrA);
	assign hitB = wrEn && (wrAddr == rdAddrB);

	// Write-through so dependent instructions issue back to back
	assign rdDataA = hitA ? wrData : regs[rdAddrA];
	assign rdDataB = hitB ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

/* tests/cpuChecker.sv */
`timescale 1ns/100ps
`default_nettype none

// Instruction-set model of the core and in-order compare of its write ports
module cpuChecker import cpuPkg::*, isaPkg::*; #(
	parameter int progMax = 64,
	parameter int imemDepth = 256,
	parameter int dmemDepth = 256
) (
	input  logic   clk,
	input  logic   rst,
	input  logic   startTest,
	input  wordT   prog [progMax],
	input  int     progLen,
	input  wordT   pc,
	input  logic   regWrEn,
	input  regIdxT regWrAddr,
	input  wordT   regWrData,
	input  logic   memWrEn,
	input  wordT   memAddr,
	input  wordT   memWrData,
	input  logic   halted,
	output int     passCount,
	output int     failCount
);
	// Cycles watched from the HLT decode on
	localparam int settleCycles = 4;

	// Expected register writes as {addr, data}
	logic [18:0] expReg [$];
	// Expected memory writes as {addr, data}
	logic [31:0] expMem [$];
	// Data memory image that persists across tests like the real one
	wordT modelMem [dmemDepth];
	wordT hltPc;
	logic active;
	int   testErrs;
	int   haltCycles;
	int   testNum;

	// Steps the program from PC 0 until HLT and records every write
	function automatic void runModel();
		wordT        regs [8];
		logic        fn;
		logic        fz;
		logic        done;
		logic        taken;
		wordT        pcM;
		wordT        pcNext;
		wordT        a;
		wordT        res;
		wordT        ea;
		logic [11:0] far;
		instrWordT   iw;
		int          steps;
		expReg.delete();
		expMem.delete();
		for (int r = 0; r < 8; r++) begin
			regs[r] = '0;
		end
		fn = 1'b0;
		fz = 1'b0;
		done = 1'b0;
		pcM = '0;
		steps = 0;
		hltPc = '0;
		while (!done && steps < 4 * progMax) begin
			if (pcM >= progLen) begin
				$display("Model ran past the end of the program at pc %0d", pcM);
				testErrs++;
				done = 1'b1;
			end else begin
				iw = prog[pcM];
				a = regs[iw.r.ra];
				pcNext = (pcM + wordT'(1)) % imemDepth;
				// Two-operand and immediate arithmetic
				case (iw.r.op)
					opAdd:   res = a + regs[iw.r.rb];
					opSub:   res = a - regs[iw.r.rb];
					opAnd:   res = a & regs[iw.r.rb];
					opOrr:   res = a | regs[iw.r.rb];
					opXor:   res = a ^ regs[iw.r.rb];
					opLsl:   res = a << regs[iw.r.rb][3:0];
					opLsr:   res = a >> regs[iw.r.rb][3:0];
					opAddi:  res = a + wordT'(iw.i.imm);
					default: res = '0;
				endcase
				ea = a + wordT'(iw.i.imm);
				far = {iw.b.cond, iw.b.off};
				case (iw.r.op)
					opAdd, opSub, opAnd, opOrr, opXor, opLsl, opLsr, opAddi: begin
						regs[iw.r.rd] = res;
						expReg.push_back({iw.r.rd, res});
						fn = res[15];
						fz = (res == '0);
					end
					opMovi: begin
						regs[iw.m.rd] = wordT'(iw.m.imm);
						expReg.push_back({iw.m.rd, wordT'(iw.m.imm)});
					end
					opLdr: begin
						regs[iw.i.rd] = modelMem[ea % dmemDepth];
						expReg.push_back({iw.i.rd, regs[iw.i.rd]});
					end
					opStr: begin
						modelMem[ea % dmemDepth] = regs[iw.i.rd];
						expMem.push_back({ea, regs[iw.i.rd]});
					end
					opB, opBl: begin
						// BL links the address after itself
						if (iw.r.op == opBl) begin
							regs[lrIdx] = pcM + wordT'(1);
							expReg.push_back({lrIdx, pcM + wordT'(1)});
						end
						pcNext = (pcM + {{4{far[11]}}, far}) % imemDepth;
					end
					opBcc: begin
						case (iw.b.cond)
							condEq:  taken = fz;
							condNe:  taken = !fz;
							condMi:  taken = fn;
							default: taken = !fn;
						endcase
						if (taken) begin
							pcNext = (pcM + {{6{iw.b.off[9]}}, iw.b.off}) % imemDepth;
						end
					end
					opBx: begin
						pcNext = a % imemDepth;
					end
					default: begin
						hltPc = pcM;
						done = 1'b1;
					end
				endcase
				pcM = pcNext;
				steps++;
			end
		end
		if (!done) begin
			$display("Model did not reach HLT within %0d steps", steps);
			testErrs++;
		end
	endfunction

	task automatic reportMismatch(string sig, wordT expV, wordT gotV);
		$display("ERR test %0d %s expected 0x%h got 0x%h", testNum, sig, expV, gotV);
		testErrs++;
	endtask

	task automatic reportEvent(string what);
		$display("Test %0d: %s", testNum, what);
		testErrs++;
	endtask

	task automatic checkRegWrite();
		logic [18:0] exp;
		if (haltCycles > 0) begin
			reportEvent("register write appeared after halt");
		end else if (expReg.size() == 0) begin
			reportEvent("register write appeared that the model never made");
		end else begin
			exp = expReg.pop_front();
			if (regWrAddr !== exp[18:16]) begin
				reportMismatch("regWrAddr", wordT'(exp[18:16]), wordT'(regWrAddr));
			end
			if (regWrData !== exp[15:0]) begin
				reportMismatch("regWrData", exp[15:0], regWrData);
			end
		end
	endtask

	task automatic checkMemWrite();
		logic [31:0] exp;
		if (haltCycles > 0) begin
			reportEvent("memory write appeared after halt");
		end else if (expMem.size() == 0) begin
			reportEvent("memory write appeared that the model never made");
		end else begin
			exp = expMem.pop_front();
			if (memAddr !== exp[31:16]) begin
				reportMismatch("memAddr", exp[31:16], memAddr);
			end
			if (memWrData !== exp[15:0]) begin
				reportMismatch("memWrData", exp[15:0], memWrData);
			end
		end
	endtask

	// Leftover entries are writes the core skipped
	task automatic finishTest();
		if (expReg.size() != 0) begin
			reportEvent($sformatf("%0d register writes never appeared", expReg.size()));
		end
		if (expMem.size() != 0) begin
			reportEvent($sformatf("%0d memory writes never appeared", expMem.size()));
		end
		active = 1'b0;
		if (testErrs == 0) begin
			$display("Test %0d passed", testNum);
			testNum++;
			passCount++;
		end else begin
			$display("Test %0d failed with %0d errors", testNum, testErrs);
			testNum++;
			failCount++;
		end
	endtask

	initial begin
		passCount = 0;
		failCount = 0;
		testNum = 0;
		active = 1'b0;
	end

	// Each edge sees the writes of the cycle that it ends
	always @(posedge clk) begin
		if (startTest) begin
			testErrs = 0;
			haltCycles = 0;
			runModel();
			active = 1'b1;
		end else if (active && !rst) begin
			if (regWrEn) begin
				checkRegWrite();
			end
			if (memWrEn) begin
				checkMemWrite();
			end
			// halted is up from the cycle after the HLT decode
			if (haltCycles > 0 && !halted) begin
				reportEvent("halted was low after HLT");
			end
			// HLT decode opens the window and the PC stays parked on the HLT word
			if (halted || haltCycles > 0 || pc === hltPc) begin
				if (pc !== hltPc) begin
					reportMismatch("pc", hltPc, pc);
				end
				haltCycles++;
			end
			if (haltCycles == settleCycles) begin
				finishTest();
			end
		end
	end

endmodule

`default_nettype wire

/* tests/cpuTb.sv */
`timescale 1ns/100ps
`default_nettype none

// Top testbench: program generation, loading and test sequencing
module cpuTb import cpuPkg::*, isaPkg::*; ();
	localparam int imemDepth = 256;
	localparam int dmemDepth = 256;
	localparam int nTests = 6;
	localparam int progMax = 64;
	// Reset cycles after the program is loaded
	localparam int holdCycles = 8;

	logic   clk;
	logic   rst;
	logic   imemWrEn;
	wordT   imemWrAddr;
	wordT   imemWrData;
	wordT   pc;
	logic   regWrEn;
	regIdxT regWrAddr;
	wordT   regWrData;
	logic   memWrEn;
	wordT   memAddr;
	wordT   memWrData;
	logic   halted;

	// Hand-off to the checker
	logic   startTest;
	wordT   curProg [progMax];
	int     curLen;
	int     passCount;
	int     failCount;

	wordT   progs [nTests][progMax];
	int     lens [nTests];
	integer seed = 32'hc175_9c53;
	int     budget;
	logic   budgetReady;

	cpuCore #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) cpuCore_i (
		.clk, .rst, .imemWrEn, .imemWrAddr, .imemWrData, .pc, .regWrEn, .regWrAddr,
		.regWrData, .memWrEn, .memAddr, .memWrData, .halted
	);

	cpuChecker #(.progMax(progMax), .imemDepth(imemDepth), .dmemDepth(dmemDepth))
	cpuChecker_i (
		.clk, .rst, .startTest, .prog(curProg), .progLen(curLen), .pc, .regWrEn,
		.regWrAddr, .regWrData, .memWrEn, .memAddr, .memWrData, .halted,
		.passCount, .failCount
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int pick(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	// Encoders, one per instruction format
	function automatic wordT regInstr(opcodeT op, regIdxT rd, regIdxT ra, regIdxT rb);
		instrWordT iw;
		iw = '0;
		iw.r.op = op;
		iw.r.rd = rd;
		iw.r.ra = ra;
		iw.r.rb = rb;
		return iw;
	endfunction

	function automatic wordT immInstr(opcodeT op, regIdxT rd, regIdxT ra, logic [5:0] imm);
		instrWordT iw;
		iw.i.op = op;
		iw.i.rd = rd;
		iw.i.ra = ra;
		iw.i.imm = imm;
		return iw;
	endfunction

	function automatic wordT moveInstr(regIdxT rd, logic [8:0] imm);
		instrWordT iw;
		iw.m.op = opMovi;
		iw.m.rd = rd;
		iw.m.imm = imm;
		return iw;
	endfunction

	// B and BL read {cond, off} as one offset
	function automatic wordT branchInstr(opcodeT op, condT cond, logic [9:0] off);
		instrWordT iw;
		iw.b.op = op;
		iw.b.cond = cond;
		iw.b.off = off;
		return iw;
	endfunction

	task automatic emit(int t, wordT w);
		progs[t][lens[t]] = w;
		lens[t]++;
	endtask

	task automatic buildPrograms();
		int prev;
		int rd;
		int base;
		logic [5:0] off;
		for (int t = 0; t < nTests; t++) begin
			lens[t] = 0;
		end
		// Test 0: random ALU and shift ops, a BCC on the flags of every fourth
		for (int r = 0; r < 7; r++) begin
			emit(0, moveInstr(regIdxT'(r), 9'(pick(512))));
		end
		for (int k = 0; k < 16; k++) begin
			emit(0, regInstr(opcodeT'(pick(7)), regIdxT'(pick(7)), regIdxT'(pick(8)),
				regIdxT'(pick(8))));
			if (k % 4 == 3) begin
				emit(0, branchInstr(opBcc, condT'(pick(4)), 10'd2));
			end
		end
		emit(0, moveInstr(3'd0, 9'(pick(512))));
		emit(0, regInstr(opHlt, 3'd0, 3'd0, 3'd0));
		// Test 1: ADDI chain, each reading the result just before it
		prev = pick(8);
		emit(1, moveInstr(regIdxT'(prev), 9'(pick(512))));
		for (int k = 0; k < 12; k++) begin
			rd = pick(8);
			emit(1, immInstr(opAddi, regIdxT'(rd), regIdxT'(prev), 6'(pick(64))));
			prev = rd;
		end
		emit(1, regInstr(opHlt, 3'd0, 3'd0, 3'd0));
		// Test 2: store, load back, then use the loaded value at once
		for (int r = 1; r < 4; r++) begin
			emit(2, moveInstr(regIdxT'(r), 9'(pick(512))));
		end
		for (int k = 0; k < 6; k++) begin
			base = 1 + pick(3);
			off = 6'(pick(64));
			rd = 5 + pick(2);
			emit(2, moveInstr(3'd4, 9'(pick(512))));
			emit(2, immInstr(opStr, 3'd4, regIdxT'(base), off));
			emit(2, immInstr(opLdr, regIdxT'(rd), regIdxT'(base), off));
			emit(2, regInstr(opAdd, 3'd0, regIdxT'(rd), 3'd4));
		end
		emit(2, regInstr(opHlt, 3'd0, 3'd0, 3'd0));
		// Test 3: flag setter, BCC skipping one MOVI, all four conditions
		emit(3, moveInstr(3'd6, 9'd1));
		emit(3, moveInstr(3'd5, 9'd15));
		for (int k = 0; k < 8; k++) begin
			case (pick(3))
				// Zero, negative, positive
				0:       emit(3, regInstr(opSub, 3'd0, 3'd1, 3'd1));
				1:       emit(3, regInstr(opLsl, 3'd0, 3'd6, 3'd5));
				default: emit(3, immInstr(opAddi, 3'd0, 3'd6, 6'(pick(64))));
			endcase
			emit(3, branchInstr(opBcc, condT'(k % 4), 10'd2));
			emit(3, moveInstr(3'd1, 9'(pick(512))));
		end
		emit(3, branchInstr(opB, condEq, 10'd2));
		emit(3, moveInstr(3'd2, 9'h1ff));
		emit(3, regInstr(opHlt, 3'd0, 3'd0, 3'd0));
		// Test 4: call at 1, subroutine at 5, return to 2
		emit(4, moveInstr(3'd1, 9'(pick(512))));
		emit(4, branchInstr(opBl, condEq, 10'd4));
		emit(4, regInstr(opAdd, 3'd3, 3'd1, 3'd2));
		emit(4, branchInstr(opB, condEq, 10'd4));
		emit(4, moveInstr(3'd4, 9'h155));
		emit(4, moveInstr(3'd2, 9'(pick(512))));
		emit(4, regInstr(opBx, 3'd0, lrIdx, 3'd0));
		emit(4, regInstr(opHlt, 3'd0, 3'd0, 3'd0));
		// Test 5: writes after HLT must never show
		emit(5, moveInstr(3'd1, 9'(pick(512))));
		emit(5, immInstr(opStr, 3'd1, 3'd0, 6'(pick(64))));
		emit(5, regInstr(opHlt, 3'd0, 3'd0, 3'd0));
		emit(5, moveInstr(3'd2, 9'(pick(512))));
		emit(5, immInstr(opStr, 3'd2, 3'd0, 6'(pick(64))));
		emit(5, regInstr(opAdd, 3'd3, 3'd1, 3'd1));
	endtask

	// Load under reset, arm the checker, release and wait for its verdict
	task automatic runTest(int t);
		@(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < progMax; i++) begin
			curProg[i] = (i < lens[t]) ? progs[t][i] : '0;
		end
		curLen = lens[t];
		for (int i = 0; i < lens[t]; i++) begin
			@(posedge clk);
			imemWrEn <= 1'b1;
			imemWrAddr <= wordT'(i);
			imemWrData <= progs[t][i];
		end
		@(posedge clk);
		imemWrEn <= 1'b0;
		startTest <= 1'b1;
		@(posedge clk);
		startTest <= 1'b0;
		repeat (holdCycles - 1) @(posedge clk);
		rst <= 1'b0;
		wait (passCount + failCount == t + 1);
	endtask

	initial begin
		rst = 1'b1;
		imemWrEn = 1'b0;
		imemWrAddr = '0;
		imemWrData = '0;
		startTest = 1'b0;
		curLen = 0;
		budgetReady = 1'b0;
		buildPrograms();
		// Loading and reset, then 20 cycles per instruction
		budget = 0;
		for (int t = 0; t < nTests; t++) begin
			budget += lens[t] + holdCycles + 2 + 20 * lens[t];
		end
		budgetReady = 1'b1;
		for (int t = 0; t < nTests; t++) begin
			runTest(t);
		end
		@(posedge clk);
		$display("Summary: %0d tests passed, %0d tests failed", passCount, failCount);
		if (failCount == 0 && passCount == nTests) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog
	initial begin
		wait (budgetReady === 1'b1);
		repeat (budget) @(posedge clk);
		$display("Watchdog expired after %0d cycles, a test never finished", budget);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
